// File: hdl/noc_pkg.sv
package noc_pkg;

    // Payload and accumulator width
    localparam int DATA_W = 64;

    // Node address width, up to 16 hops
    localparam int NODE_W = 4;

    // Sequence tag width, wraps modulo 256
    localparam int TAG_W = 8;

    // Flit opcodes
    typedef enum logic [1:0] {
        OP_ACC    = 2'd0,
        OP_CLR    = 2'd1,
        OP_READ   = 2'd2,
        OP_RESULT = 2'd3
    } opcode_e;

    // Injection port word, 70 bits
    typedef struct packed {
        opcode_e             op;
        logic [NODE_W-1:0]   dest;
        logic [DATA_W-1:0]   data;
    } req_t;

    // Link and ejection word, 78 bits
    // Tag sits between the header and the payload
    typedef struct packed {
        opcode_e             op;
        logic [NODE_W-1:0]   dest;
        logic [TAG_W-1:0]    tag;
        logic [DATA_W-1:0]   data;
    } flit_t;

endpackage

// File: hdl/flit_packer.sv
module flit_packer (
    input  logic          clk,
    input  logic          reset,
    input  logic          in_valid,
    input  noc_pkg::req_t in_req,
    output logic          flit_valid,
    output noc_pkg::flit_t flit
);

    import noc_pkg::*;

    // Tag for the next accepted request
    logic [TAG_W-1:0] tag_cnt;

    // Control path
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flit_valid <= 1'b0;
            tag_cnt    <= '0;
        end else begin
            flit_valid <= in_valid;
            if (in_valid) begin
                tag_cnt <= tag_cnt + 1'b1;
            end
        end
    end

    // Payload path
    // Source credit already reserved the slot in hop 0, so no stall here
    always_ff @(posedge clk) begin
        if (in_valid) begin
            flit.op   <= in_req.op;
            flit.dest <= in_req.dest;
            flit.tag  <= tag_cnt;
            flit.data <= in_req.data;
        end
    end

endmodule

// File: hdl/node_accumulator.sv
module node_accumulator (
    input  logic           clk,
    input  logic           reset,
    input  logic           exec,
    input  noc_pkg::flit_t op_flit,
    output noc_pkg::flit_t result_flit
);

    import noc_pkg::*;

    // Running sum of this node, wraps modulo 2^64
    logic [DATA_W-1:0] sum;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sum <= '0;
        end else if (exec) begin
            case (op_flit.op)
                OP_ACC: begin
                    sum <= sum + op_flit.data;
                end
                OP_CLR: begin
                    sum <= '0;
                end
                // READ and RESULT leave the sum alone
                default: begin
                    sum <= sum;
                end
            endcase
        end
    end

    // Reply flit built from the sum as it stands before this pop
    always_comb begin
        result_flit.op   = OP_RESULT;
        result_flit.dest = op_flit.dest;
        result_flit.tag  = op_flit.tag;
        result_flit.data = sum;
    end

endmodule

// File: hdl/router_hop.sv
module router_hop #(
    parameter int NODE_ADDR = 0,
    parameter int BUF_DEPTH = 4
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           in_valid,
    input  noc_pkg::flit_t in_flit,
    output logic           head_valid,
    output logic           needs_fwd,
    input  logic           pop,
    output logic           fwd_valid,
    output noc_pkg::flit_t fwd_flit
);

    import noc_pkg::*;

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);
    localparam logic [NODE_W-1:0] MY_ADDR = NODE_W'(NODE_ADDR);

    flit_t             buf_mem [BUF_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;

    flit_t             head;
    logic              is_local;
    logic              exec;
    flit_t             result_flit;

    // Circular pointer advance, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(BUF_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Head decode
    assign head       = buf_mem[rd_ptr];
    assign head_valid = (count != '0);
    assign is_local   = (head.dest == MY_ADDR);
    // A local READ goes on as a RESULT
    assign needs_fwd  = !is_local || (head.op == OP_READ);
    assign exec       = pop && is_local;

    // Buffer storage
    always_ff @(posedge clk) begin
        if (in_valid) begin
            buf_mem[wr_ptr] <= in_flit;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Forward register, one cycle after the pop
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fwd_valid <= 1'b0;
        end else begin
            fwd_valid <= pop && needs_fwd;
        end
    end

    always_ff @(posedge clk) begin
        if (pop && needs_fwd) begin
            fwd_flit <= is_local ? result_flit : head;
        end
    end

    node_accumulator u_acc (
        .clk         (clk),
        .reset       (reset),
        .exec        (exec),
        .op_flit     (head),
        .result_flit (result_flit)
    );

endmodule

// File: hdl/credit_ctrl.sv
module credit_ctrl #(
    parameter int NUM_NODES   = 4,
    parameter int BUF_DEPTH   = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [NUM_NODES-1:0] head_valid,
    input  logic [NUM_NODES-1:0] needs_fwd,
    output logic [NUM_NODES-1:0] pop,
    input  logic                 out_credit,
    output logic                 in_credit
);

    localparam int MAX_CREDIT = (BUF_DEPTH > OUT_CREDITS) ? BUF_DEPTH : OUT_CREDITS;
    localparam int CNT_W      = $clog2(MAX_CREDIT + 1);

    // Credits of hop k toward its downstream side
    // Last entry counts free slots at the sink
    logic [CNT_W-1:0]     cnt [NUM_NODES];
    logic [NUM_NODES-1:0] take;
    logic [NUM_NODES-1:0] ret;
    logic [NUM_NODES-1:0] pop_q;

    // Pop returns a slot upstream one cycle later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pop_q <= '0;
        end else begin
            pop_q <= pop;
        end
    end

    assign in_credit = pop_q[0];

    for (genvar k = 0; k < NUM_NODES; k++) begin : g_link
        localparam int INIT = (k == NUM_NODES - 1) ? OUT_CREDITS : BUF_DEPTH;

        // Grant rule
        assign pop[k]  = head_valid[k] && (!needs_fwd[k] || (cnt[k] != '0));
        assign take[k] = pop[k] && needs_fwd[k];

        if (k == NUM_NODES - 1) begin : g_out
            assign ret[k] = out_credit;
        end else begin : g_mid
            assign ret[k] = pop_q[k+1];
        end

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                cnt[k] <= CNT_W'(INIT);
            end else begin
                case ({ret[k], take[k]})
                    2'b10:   cnt[k] <= cnt[k] + 1'b1;
                    2'b01:   cnt[k] <= cnt[k] - 1'b1;
                    default: cnt[k] <= cnt[k];
                endcase
            end
        end
    end

endmodule

// File: hdl/noc_chain_top.sv
module noc_chain_top #(
    parameter int NUM_NODES   = 4,
    parameter int BUF_DEPTH   = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           in_valid,
    input  noc_pkg::req_t  in_req,
    output logic           in_credit,
    output logic           out_valid,
    output noc_pkg::flit_t out_flit,
    input  logic           out_credit
);

    import noc_pkg::*;

    // Link k feeds hop k, link NUM_NODES is the ejection port
    logic [NUM_NODES:0]   link_valid;
    flit_t                link_flit [NUM_NODES+1];

    logic [NUM_NODES-1:0] head_valid;
    logic [NUM_NODES-1:0] needs_fwd;
    logic [NUM_NODES-1:0] pop;

    flit_packer u_packer (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .flit_valid (link_valid[0]),
        .flit       (link_flit[0])
    );

    for (genvar k = 0; k < NUM_NODES; k++) begin : g_hop
        router_hop #(
            .NODE_ADDR (k),
            .BUF_DEPTH (BUF_DEPTH)
        ) u_hop (
            .clk        (clk),
            .reset      (reset),
            .in_valid   (link_valid[k]),
            .in_flit    (link_flit[k]),
            .head_valid (head_valid[k]),
            .needs_fwd  (needs_fwd[k]),
            .pop        (pop[k]),
            .fwd_valid  (link_valid[k+1]),
            .fwd_flit   (link_flit[k+1])
        );
    end

    // All link credits live in one place
    credit_ctrl #(
        .NUM_NODES   (NUM_NODES),
        .BUF_DEPTH   (BUF_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_credit (
        .clk        (clk),
        .reset      (reset),
        .head_valid (head_valid),
        .needs_fwd  (needs_fwd),
        .pop        (pop),
        .out_credit (out_credit),
        .in_credit  (in_credit)
    );

    assign out_valid = link_valid[NUM_NODES];
    assign out_flit  = link_flit[NUM_NODES];

endmodule

// File: verification/noc_chain_tb.sv
module noc_chain_tb;

    import noc_pkg::*;

    localparam int    NUM_NODES   = 4;
    localparam int    BUF_DEPTH   = 4;
    localparam int    OUT_CREDITS = 2;
    localparam int    PERIOD      = 4;
    localparam string CASES_FILE  = "verification/noc_chain_cases.txt";

    logic  clk;
    logic  reset;
    logic  in_valid;
    req_t  in_req;
    logic  in_credit;
    logic  out_valid;
    flit_t out_flit;
    logic  out_credit;

    // Cases as read from the file, each entry tagged with its test index
    req_t  req_q[$];
    int    req_test[$];
    flit_t exp_q[$];
    int    exp_test[$];
    int    test_id[$];
    int    test_stall[$];

    // Flits the running test still waits for, in order
    flit_t exp_cur[$];
    flit_t mon_exp;

    int          src_credit;
    int          in_credit_total;
    int          out_valid_total;
    int          out_credit_total;
    int          owed;
    int          stall_left;
    bit          stall_mode;
    int          error_count;
    int          pass_tests;
    int          fail_tests;
    bit          loaded;
    bit          cases_ok;
    logic [31:0] lfsr_state;

    noc_chain_top #(
        .NUM_NODES   (NUM_NODES),
        .BUF_DEPTH   (BUF_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) dut (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_flit   (out_flit),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Sink hold-off of 0 to 7 cycles
    task automatic draw_stall(output int len);
        len = 0;
        for (int i = 0; i < 3; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            len = (len << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic check_flit(input string name, input flit_t got, input flit_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic load_cases(output bit ok);
        int                fd;
        int                n;
        int                cur;
        int                f_a;
        int                f_op;
        int                f_dest;
        int                f_tag;
        logic [DATA_W-1:0] f_data;
        string             line;
        req_t              r;
        flit_t             f;
        ok  = 1'b1;
        cur = -1;
        fd  = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the cases file %s", CASES_FILE);
            ok = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0) begin
                case (line.getc(0))
                    "T": begin
                        n = $sscanf(line, "T %d %d", f_a, f_op);
                        cur++;
                        test_id.push_back(f_a);
                        test_stall.push_back(f_op);
                    end
                    "R": begin
                        n = $sscanf(line, "R %h %h %h", f_op, f_dest, f_data);
                        r.op   = opcode_e'(f_op[1:0]);
                        r.dest = f_dest[NODE_W-1:0];
                        r.data = f_data;
                        req_q.push_back(r);
                        req_test.push_back(cur);
                    end
                    "E": begin
                        n = $sscanf(line, "E %h %h %h %h", f_op, f_dest, f_tag, f_data);
                        f.op   = opcode_e'(f_op[1:0]);
                        f.dest = f_dest[NODE_W-1:0];
                        f.tag  = f_tag[TAG_W-1:0];
                        f.data = f_data;
                        exp_q.push_back(f);
                        exp_test.push_back(cur);
                    end
                    // Comments and blank lines
                    default: n = 0;
                endcase
                if (cur < 0 && n > 0) begin
                    $display("Cases file has a request or result line before any test line");
                    ok = 1'b0;
                end
            end
        end
        $fclose(fd);
    endtask

    // Called at one time unit after a rising edge, returns at the same phase
    task automatic send_req(input req_t r);
        while (src_credit == 0) begin
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        in_req   = r;
        src_credit--;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic run_test(input int t);
        int base_err;
        int base_credit;
        int sent;
        int n_exp;
        int waited;
        base_err    = error_count;
        base_credit = in_credit_total;
        sent        = 0;
        n_exp       = 0;
        stall_mode  = (test_stall[t] != 0);
        stall_left  = 0;
        foreach (exp_q[i]) begin
            if (exp_test[i] == t) begin
                exp_cur.push_back(exp_q[i]);
                n_exp++;
            end
        end
        foreach (req_q[i]) begin
            if (req_test[i] == t) begin
                send_req(req_q[i]);
                sent++;
            end
        end
        waited = 0;
        while ((exp_cur.size() != 0 || in_credit_total - base_credit != sent)
               && waited < 100 * (sent + 1)) begin
            @(posedge clk);
            waited++;
        end
        if (exp_cur.size() != 0) begin
            $display("Test %0d: %0d expected flits never left the chain",
                     test_id[t], exp_cur.size());
            error_count++;
            exp_cur.delete();
        end
        // Room for a stray or repeated flit to show up
        repeat (4 * NUM_NODES) @(posedge clk);
        #1;
        check_count("in_credit pulses", in_credit_total - base_credit, sent);
        stall_mode = 1'b0;
        if (error_count == base_err) begin
            pass_tests++;
        end else begin
            fail_tests++;
        end
        $display("Test %0d: %s, %0d requests, %0d flits expected", test_id[t],
                 (error_count == base_err) ? "ok" : "errors", sent, n_exp);
    endtask

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (in_credit) begin
                src_credit++;
                in_credit_total++;
            end
            if (out_valid) begin
                out_valid_total++;
                owed++;
                if (out_valid_total > OUT_CREDITS + out_credit_total) begin
                    $display("Ejection port sent flit %0d with only %0d credits granted",
                             out_valid_total, OUT_CREDITS + out_credit_total);
                    error_count++;
                end
                if (exp_cur.size() == 0) begin
                    $display("Unexpected flit %h at the ejection port at time %0t",
                             out_flit, $time);
                    error_count++;
                end else begin
                    mon_exp = exp_cur.pop_front();
                    check_flit("out_flit", out_flit, mon_exp);
                end
            end
        end
    end

    // Sink frees one slot per cycle, with random hold-off in stall tests
    initial begin
        forever begin
            @(posedge clk);
            #1;
            out_credit = 1'b0;
            if (!reset && owed > 0) begin
                if (stall_mode && stall_left > 0) begin
                    stall_left--;
                end else begin
                    out_credit = 1'b1;
                    owed--;
                    out_credit_total++;
                    if (stall_mode) begin
                        draw_stall(stall_left);
                    end
                end
            end
        end
    end

    initial begin
        wait (loaded);
        repeat ((req_q.size() + 1) * 200) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles",
                 (req_q.size() + 1) * 200);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_req     = '0;
        out_credit = 1'b0;
        src_credit = BUF_DEPTH;
        lfsr_state = 32'h5e4243e1;
        load_cases(cases_ok);
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        if (cases_ok) begin
            for (int t = 0; t < test_id.size(); t++) begin
                run_test(t);
            end
        end
        $display("Tests: %0d passed, %0d failed, %0d errors", pass_tests, fail_tests,
                 error_count);
        if (cases_ok && fail_tests == 0 && error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: verification/noc_chain_cases.txt
# T <test id> <sink stall 0 or 1>;  R <op> <dest> <data>;  E <op> <dest> <tag> <data>
# All R and E fields hex, op 0 ACC 1 CLR 2 READ 3 RESULT, tags count requests from 0
T 1 0
R 0 2 FFFFFFFFFFFFFFFF
R 0 2 0000000000000003
R 0 2 0000000000000010
R 2 2 0000000000000000
E 3 2 03 0000000000000012
T 2 0
R 0 1 0000000000000100
R 2 1 0000000000000000
R 1 1 0000000000000000
R 0 1 0000000000000005
R 0 1 0000000000000007
R 2 1 0000000000000000
E 3 1 05 0000000000000100
E 3 1 09 000000000000000C
T 3 0
R 1 1 0000000000000000
R 1 2 0000000000000000
R 0 0 0000000000000011
R 0 3 0000000000000022
R 0 1 0000000000000033
R 0 2 0000000000000044
R 0 0 0000000000000001
R 0 3 0000000000000002
R 2 3 0000000000000000
R 2 0 0000000000000000
R 2 2 0000000000000000
R 2 1 0000000000000000
E 3 3 12 0000000000000024
E 3 0 13 0000000000000012
E 3 2 14 0000000000000044
E 3 1 15 0000000000000033
T 4 0
R 0 9 DEADBEEF00000001
R 2 F 0123456789ABCDEF
R 1 4 0000000000000055
R 2 3 0000000000000000
E 0 9 16 DEADBEEF00000001
E 2 F 17 0123456789ABCDEF
E 1 4 18 0000000000000055
E 3 3 19 0000000000000024
T 5 1
R 0 0 0000000000001000
R 2 0 0000000000000000
R 0 8 000000000000AAAA
R 0 2 0000000000000006
R 2 2 0000000000000000
R 2 1 0000000000000000
R 0 5 000000000000BBBB
R 2 3 0000000000000000
R 0 3 FFFFFFFFFFFFFFDC
R 2 3 0000000000000000
R 0 7 000000000000CCCC
R 2 0 0000000000000000
E 3 0 1B 0000000000001012
E 0 8 1C 000000000000AAAA
E 3 2 1E 000000000000004A
E 3 1 1F 0000000000000033
E 0 5 20 000000000000BBBB
E 3 3 21 0000000000000024
E 3 3 23 0000000000000000
E 0 7 24 000000000000CCCC
E 3 0 25 0000000000001012

// File: tb.f
hdl/noc_pkg.sv
hdl/flit_packer.sv
hdl/node_accumulator.sv
hdl/router_hop.sv
hdl/credit_ctrl.sv
hdl/noc_chain_top.sv
verification/noc_chain_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the noc_chain testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -Wno-fatal --top-module noc_chain_tb -f tb.f \
    -o noc_chain_sim \
    && ./obj_dir/noc_chain_sim > "$LOG" 2>&1 \
    || echo "Build or simulation stopped with an error"

cat "$LOG" 2>/dev/null

# The log decides pass or fail
grep -qx "Result: PASSED" "$LOG" && exit 0 || exit 1
